//--- tcb_trace.f
common/tcb_pkg.sv
common/trace_pkg.sv
hw/tcb_mem.sv
tcb_mon/tcb_mon_capture.sv
tcb_mon/tcb_mon_stats.sv
tcb_mon/tcb_mon_fifo.sv
hw/tcb_trace_top.sv
tests/tcb_trace_clk.sv
tests/tcb_trace_check.sv
tests/tcb_trace_tb.sv

//--- Bender.yml
package:
  name: tcb_trace

sources:
  # packages first, the RTL depends on them
  - common/tcb_pkg.sv
  - common/trace_pkg.sv
  - hw/tcb_mem.sv
  - tcb_mon/tcb_mon_capture.sv
  - tcb_mon/tcb_mon_stats.sv
  - tcb_mon/tcb_mon_fifo.sv
  - hw/tcb_trace_top.sv
  # testbench, top module tcb_trace_tb
  - target: test
    files:
      - tests/tcb_trace_clk.sv
      - tests/tcb_trace_check.sv
      - tests/tcb_trace_tb.sv

//--- tests/tcb_trace_tb.sv
module tcb_trace_tb;

  import tcb_pkg::*;
  import trace_pkg::*;

  localparam int unsigned clk_period   = 20;
  localparam int unsigned run_cycles   = 2000;
  localparam int unsigned drain_cycles = 16;
  // reset, preload, random run, drain and some slack
  localparam int unsigned limit_cycles = 2 + mem_words + run_cycles + drain_cycles + 64;

  logic         bus;
  logic         arst_n;
  logic         stall;
  tcb_req_t     req;
  logic         rdy;
  tcb_rsp_t     rsp;
  logic         trc_pop;
  logic         stat_clr;
  logic         trc_vld;
  trace_rec_t   trc;
  trace_stats_t stats;
  logic         run_done;
  int unsigned  errors;

  tcb_trace_clk tcb_trace_clk_inst (.bus(bus), .arst_n(arst_n));

  tcb_trace_top tcb_trace_top_inst (
    .bus(bus), .arst_n(arst_n), .stall(stall), .req(req), .rdy(rdy), .rsp(rsp),
    .trc_pop(trc_pop), .stat_clr(stat_clr), .trc_vld(trc_vld), .trc(trc), .stats(stats)
  );

  tcb_trace_check tcb_trace_check_inst (
    .bus(bus), .arst_n(arst_n), .stall(stall), .req(req), .rdy(rdy), .rsp(rsp),
    .trc_pop(trc_pop), .stat_clr(stat_clr), .trc_vld(trc_vld), .trc(trc), .stats(stats),
    .done(run_done), .errors(errors)
  );

  // preload pattern, different for every word index
  function automatic logic [tcb_dw-1:0] fill_word(input logic [mem_iw-1:0] w);
    return {8'ha5, w, ~w, w ^ 8'h3c};
  endfunction

  function automatic tcb_req_t random_request();
    tcb_req_t r;
    r.vld  = ($urandom_range(0, 99) < 80);
    r.wen  = $urandom_range(0, 1);
    r.kind = access_kind_e'($urandom_range(0, 2));
    r.ben  = $urandom_range(0, 15);
    r.wdt  = $urandom;
    // mostly inside the memory, now and then past its end
    if ($urandom_range(0, 99) < 90) begin
      r.adr = $urandom_range(0, mem_limit - 1);
    end else begin
      r.adr = mem_limit + $urandom_range(0, 32'h00ff_ffff);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus manager
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed_ret;
    tcb_req_t    fill;
    seed_ret = $urandom(22698);
    stall    = 1'b0;
    req      = '0;
    trc_pop  = 1'b0;
    stat_clr = 1'b0;
    run_done = 1'b0;
    wait (arst_n === 1'b1);
    // write every word once, stall stays low here
    for (int i = 0; i < mem_words; i++) begin
      @(posedge bus);
      fill = '{vld: 1'b1, wen: 1'b1, kind: kind_lsu, adr: i << tcb_bo, ben: '1,
               wdt: fill_word(i)};
      req     <= fill;
      trc_pop <= ($urandom_range(0, 99) < 60);
    end
    for (int cyc = 0; cyc < run_cycles; cyc++) begin
      @(posedge bus);
      // request not taken at this edge stays on the bus
      if (!(req.vld && !rdy)) begin
        req <= random_request();
      end
      stall    <= ($urandom_range(0, 99) < 25);
      trc_pop  <= ($urandom_range(0, 99) < 60);
      stat_clr <= (cyc == 700 || cyc == 1400);
    end
    // let the last request through, then empty the buffer
    for (int cyc = 0; cyc < drain_cycles; cyc++) begin
      @(posedge bus);
      if (!(req.vld && !rdy)) begin
        req.vld <= 1'b0;
      end
      stall    <= 1'b0;
      trc_pop  <= 1'b1;
      stat_clr <= 1'b0;
    end
    @(posedge bus);
    run_done = 1'b1;
    #1;
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(limit_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, stimulus never finished", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

//--- tests/tcb_trace_check.sv
module tcb_trace_check (
  input  logic                    bus,
  input  logic                    arst_n,
  input  logic                    stall,
  input  tcb_pkg::tcb_req_t       req,
  input  logic                    rdy,
  input  tcb_pkg::tcb_rsp_t       rsp,
  input  logic                    trc_pop,
  input  logic                    stat_clr,
  input  logic                    trc_vld,
  input  trace_pkg::trace_rec_t   trc,
  input  trace_pkg::trace_stats_t stats,
  input  logic                    done,
  output int unsigned             errors
);

  import tcb_pkg::*;
  import trace_pkg::*;

  // reference copy of the memory
  logic [tcb_dw-1:0] mem_model [mem_words];
  // transfer of the last edge whose response is due now
  logic              pend_vld;
  trace_rec_t        pend_rec;
  logic [tcb_dw-1:0] pend_rdt;
  // expected buffer contents with the oldest first
  trace_rec_t        exp_q [$];
  trace_stats_t      exp_stats;
  int unsigned       checks;

  task automatic flag_error(input string msg);
    errors++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // comparisons mid cycle where all outputs are settled
  ////////////////////////////////////////////////////////////

  task automatic compare_outputs();
    checks++;
    if (rdy !== ~stall) begin
      flag_error($sformatf("rdy is %b while stall is %b", rdy, stall));
    end
    if (pend_vld && (rsp.rdt !== pend_rdt || rsp.err !== pend_rec.err)) begin
      flag_error($sformatf("response for %h: rdt %h err %b, expected rdt %h err %b",
                           pend_rec.adr, rsp.rdt, rsp.err, pend_rdt, pend_rec.err));
    end
    if (trc_vld !== (exp_q.size() != 0)) begin
      flag_error($sformatf("trc_vld %b with %0d records expected", trc_vld, exp_q.size()));
    end else if (trc_vld && trc !== exp_q[0]) begin
      flag_error($sformatf("trace record %h, expected %h", trc, exp_q[0]));
    end
    if (stats !== exp_stats) begin
      flag_error($sformatf("counters %h, expected %h", stats, exp_stats));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // model update for the coming edge
  ////////////////////////////////////////////////////////////

  task automatic step_model();
    logic              full;
    logic              oor;
    logic [mem_iw-1:0] idx;
    // fullness before this edge decides a drop
    full = (exp_q.size() == trace_depth);
    if (trc_pop && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    if (pend_vld && !full) begin
      exp_q.push_back(pend_rec);
    end
    if (stat_clr) begin
      exp_stats = '0;
    end else if (pend_vld) begin
      if (full && exp_stats.drop_cnt != cnt_max) begin
        exp_stats.drop_cnt = exp_stats.drop_cnt + 1'b1;
      end
      if (pend_rec.err && exp_stats.err_cnt != cnt_max) begin
        exp_stats.err_cnt = exp_stats.err_cnt + 1'b1;
      end
      case (pend_rec.kind)
        kind_ifu: if (exp_stats.ifu_cnt != cnt_max) exp_stats.ifu_cnt = exp_stats.ifu_cnt + 1'b1;
        kind_lsu: if (exp_stats.lsu_cnt != cnt_max) exp_stats.lsu_cnt = exp_stats.lsu_cnt + 1'b1;
        kind_gpr: if (exp_stats.gpr_cnt != cnt_max) exp_stats.gpr_cnt = exp_stats.gpr_cnt + 1'b1;
        default: ;
      endcase
    end
    // new transfer when the manager is not stalled
    pend_vld = req.vld && !stall;
    if (pend_vld) begin
      oor = (req.adr >= mem_limit);
      idx = req.adr[tcb_bo +: mem_iw];
      pend_rdt = (req.wen || oor) ? '0 : mem_model[idx];
      pend_rec = '{kind: req.kind, wen: req.wen, adr: req.adr, ben: req.ben,
                   dat: req.wen ? req.wdt : pend_rdt, err: oor};
      // byte lanes merge into the old word
      for (int b = 0; b < tcb_bw; b++) begin
        if (req.wen && !oor && req.ben[b]) mem_model[idx][8*b +: 8] = req.wdt[8*b +: 8];
      end
    end
  endtask

  always @(negedge bus) begin
    if (arst_n !== 1'b1) begin
      pend_vld  = 1'b0;
      exp_stats = '0;
      exp_q.delete();
    end else begin
      compare_outputs();
      step_model();
    end
  end

  // closing report
  initial begin
    errors = 0;
    checks = 0;
    wait (done === 1'b1);
    $display("checker: %0d cycles compared, %0d errors", checks, errors);
  end

endmodule

//--- tests/tcb_trace_clk.sv
module tcb_trace_clk (
  output logic bus,
  output logic arst_n
);

  // free running clock, 20 units per period
  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  // reset held over the first two rising edges
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge bus);
    // release lands after the DUT has seen the edge
    arst_n <= 1'b1;
  end

endmodule

//--- hw/tcb_trace_top.sv
module tcb_trace_top (
  input  logic                    bus,
  input  logic                    arst_n,
  input  logic                    stall,
  input  tcb_pkg::tcb_req_t       req,
  output logic                    rdy,
  output tcb_pkg::tcb_rsp_t       rsp,
  input  logic                    trc_pop,
  input  logic                    stat_clr,
  output logic                    trc_vld,
  output trace_pkg::trace_rec_t   trc,
  output trace_pkg::trace_stats_t stats
);

  import trace_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // record from the capture stage
  logic       rec_vld;
  trace_rec_t rec;

  // counters before packing
  logic [cnt_w-1:0] ifu_cnt;
  logic [cnt_w-1:0] lsu_cnt;
  logic [cnt_w-1:0] gpr_cnt;
  logic [cnt_w-1:0] err_cnt;
  logic [cnt_w-1:0] drop_cnt;

  ////////////////////////////////////////////////////////////
  // subordinate and monitor
  ////////////////////////////////////////////////////////////

  tcb_mem tcb_mem_inst (
    .bus    (bus),
    .arst_n (arst_n),
    .stall  (stall),
    .req    (req),
    .rdy    (rdy),
    .rsp    (rsp)
  );

  // monitor taps the same bus wires
  tcb_mon_capture tcb_mon_capture_inst (
    .bus     (bus),
    .arst_n  (arst_n),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .rec_vld (rec_vld),
    .rec     (rec)
  );

  tcb_mon_fifo tcb_mon_fifo_inst (
    .bus      (bus),
    .arst_n   (arst_n),
    .rec_vld  (rec_vld),
    .rec      (rec),
    .pop      (trc_pop),
    .clr      (stat_clr),
    .trc_vld  (trc_vld),
    .trc      (trc),
    .drop_cnt (drop_cnt)
  );

  tcb_mon_stats tcb_mon_stats_inst (
    .bus     (bus),
    .arst_n  (arst_n),
    .rec_vld (rec_vld),
    .rec     (rec),
    .clr     (stat_clr),
    .ifu_cnt (ifu_cnt),
    .lsu_cnt (lsu_cnt),
    .gpr_cnt (gpr_cnt),
    .err_cnt (err_cnt)
  );

  // drop count sits with the rest of the statistics
  assign stats.ifu_cnt  = ifu_cnt;
  assign stats.lsu_cnt  = lsu_cnt;
  assign stats.gpr_cnt  = gpr_cnt;
  assign stats.err_cnt  = err_cnt;
  assign stats.drop_cnt = drop_cnt;

endmodule

//--- tcb_mon/tcb_mon_fifo.sv
module tcb_mon_fifo (
  input  logic                        bus,
  input  logic                        arst_n,
  input  logic                        rec_vld,
  input  trace_pkg::trace_rec_t       rec,
  input  logic                        pop,
  input  logic                        clr,
  output logic                        trc_vld,
  output trace_pkg::trace_rec_t       trc,
  output logic [trace_pkg::cnt_w-1:0] drop_cnt
);

  import trace_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // record storage
  trace_rec_t buf_mem [trace_depth];

  // pointers wrap on their own
  logic [trace_aw-1:0] wr_ptr;
  logic [trace_aw-1:0] rd_ptr;
  // records currently held
  logic [trace_cw-1:0] occ;

  logic full;
  logic push;
  logic take;

  // full means drop, even with a pop in the same cycle
  assign full = (occ == trace_full);
  assign push = rec_vld & ~full;
  assign take = pop & trc_vld;

  ////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (take) rd_ptr <= rd_ptr + 1'b1;
      case ({push, take})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        // both or neither, level unchanged
        default: ;
      endcase
    end
  end

  // storage write
  always_ff @(posedge bus) begin
    if (push) buf_mem[wr_ptr] <= rec;
  end

  // oldest record falls through
  assign trc_vld = (occ != '0);
  assign trc     = buf_mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // drop counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      drop_cnt <= '0;
    end else if (clr) begin
      drop_cnt <= '0;
    end else if (rec_vld && full && drop_cnt != cnt_max) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

//--- tcb_mon/tcb_mon_stats.sv
module tcb_mon_stats (
  input  logic                        bus,
  input  logic                        arst_n,
  input  logic                        rec_vld,
  input  trace_pkg::trace_rec_t       rec,
  input  logic                        clr,
  output logic [trace_pkg::cnt_w-1:0] ifu_cnt,
  output logic [trace_pkg::cnt_w-1:0] lsu_cnt,
  output logic [trace_pkg::cnt_w-1:0] gpr_cnt,
  output logic [trace_pkg::cnt_w-1:0] err_cnt
);

  import tcb_pkg::*;
  import trace_pkg::*;

  // add one, stick at the top
  function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] val);
    return (val == cnt_max) ? val : val + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // per kind counters
  ////////////////////////////////////////////////////////////

  // clear wins over a record in the same cycle
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ifu_cnt <= '0;
      lsu_cnt <= '0;
      gpr_cnt <= '0;
    end else if (clr) begin
      ifu_cnt <= '0;
      lsu_cnt <= '0;
      gpr_cnt <= '0;
    end else if (rec_vld) begin
      case (rec.kind)
        kind_ifu: ifu_cnt <= sat_inc(ifu_cnt);
        kind_lsu: lsu_cnt <= sat_inc(lsu_cnt);
        kind_gpr: gpr_cnt <= sat_inc(gpr_cnt);
        // unused encoding, not counted
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // error counter
  ////////////////////////////////////////////////////////////

  // any kind can fail
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      err_cnt <= '0;
    end else if (clr) begin
      err_cnt <= '0;
    end else if (rec_vld && rec.err) begin
      err_cnt <= sat_inc(err_cnt);
    end
  end

endmodule

//--- tcb_mon/tcb_mon_capture.sv
module tcb_mon_capture (
  input  logic                  bus,
  input  logic                  arst_n,
  input  tcb_pkg::tcb_req_t     req,
  input  logic                  rdy,
  input  tcb_pkg::tcb_rsp_t     rsp,
  output logic                  rec_vld,
  output trace_pkg::trace_rec_t rec
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // transfer seen on the current edge
  logic xfer;

  // request phase held back by tcb_dly edges
  tcb_req_t dly_req;
  // transfer flag held back the same way
  logic     dly_xfer;

  ////////////////////////////////////////////////////////////
  // request delay line
  ////////////////////////////////////////////////////////////

  assign xfer = req.vld & rdy;

  // transfer flag delay
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      dly_xfer <= 1'b0;
    end else begin
      dly_xfer <= xfer;
    end
  end

  // payload copy on each transfer
  always_ff @(posedge bus) begin
    if (xfer) begin
      dly_req <= req;
    end
  end

  ////////////////////////////////////////////////////////////
  // record assembly
  ////////////////////////////////////////////////////////////

  // response cycle
  // old request meets live response
  assign rec_vld = dly_xfer;

  always_comb begin
    rec.kind = dly_req.kind;
    rec.wen  = dly_req.wen;
    rec.adr  = dly_req.adr;
    rec.ben  = dly_req.ben;
    // writes log what went out, reads log what came back
    if (dly_req.wen) begin
      rec.dat = dly_req.wdt;
    end else begin
      rec.dat = rsp.rdt;
    end
    // error belongs to the response phase
    rec.err  = rsp.err;
  end

endmodule

//--- hw/tcb_mem.sv
module tcb_mem (
  input  logic              bus,
  input  logic              arst_n,
  input  logic              stall,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  // word storage
  logic [tcb_dw-1:0] mem [mem_words];

  // transfer on this edge
  logic xfer;
  // address beyond the last word
  logic oor;
  // word index from the byte address
  logic [mem_iw-1:0] idx;

  ////////////////////////////////////////////////////////////
  // handshake and decode
  ////////////////////////////////////////////////////////////

  // stall only holds the manager off
  assign rdy  = ~stall;
  assign xfer = req.vld & rdy;
  assign oor  = (req.adr >= mem_limit);
  assign idx  = req.adr[tcb_bo +: mem_iw];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // byte lane writes, out of range writes are lost
  always_ff @(posedge bus) begin
    if (xfer && req.wen && !oor) begin
      for (int i = 0; i < tcb_bw; i++) begin
        if (req.ben[i]) begin
          mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  // read word on a good read, zero otherwise
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rsp.rdt <= '0;
      rsp.err <= 1'b0;
    end else if (xfer) begin
      rsp.err <= oor;
      rsp.rdt <= (!req.wen && !oor) ? mem[idx] : '0;
    end else begin
      // idle cycle, nothing to report
      rsp.rdt <= '0;
      rsp.err <= 1'b0;
    end
  end

endmodule

//--- common/trace_pkg.sv
package trace_pkg;

  ////////////////////////////////////////////////////////////
  // trace buffer sizes
  ////////////////////////////////////////////////////////////

  // number of records held before dropping
  localparam int unsigned trace_depth = 8;
  // pointer width, depth is a power of two
  localparam int unsigned trace_aw = $clog2(trace_depth);
  // occupancy needs one extra bit to tell full from empty
  localparam int unsigned trace_cw = trace_aw + 1;
  localparam logic [trace_cw-1:0] trace_full = trace_cw'(trace_depth);

  // statistics counters
  localparam int unsigned cnt_w = 16;
  localparam logic [cnt_w-1:0] cnt_max = '1;

  ////////////////////////////////////////////////////////////
  // records
  ////////////////////////////////////////////////////////////

  // one paired request and response
  typedef struct packed {
    tcb_pkg::access_kind_e      kind;
    logic                       wen;
    logic [tcb_pkg::tcb_aw-1:0] adr;
    logic [tcb_pkg::tcb_bw-1:0] ben;
    // write data on writes, read data on reads
    logic [tcb_pkg::tcb_dw-1:0] dat;
    logic                       err;
  } trace_rec_t;

  // counter snapshot seen at the top level
  typedef struct packed {
    logic [cnt_w-1:0] ifu_cnt;
    logic [cnt_w-1:0] lsu_cnt;
    logic [cnt_w-1:0] gpr_cnt;
    logic [cnt_w-1:0] err_cnt;
    logic [cnt_w-1:0] drop_cnt;
  } trace_stats_t;

endpackage

//--- common/tcb_pkg.sv
package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus sizes
  ////////////////////////////////////////////////////////////

  // address and data width
  localparam int unsigned tcb_aw = 32;
  localparam int unsigned tcb_dw = 32;
  // one enable per data byte
  localparam int unsigned tcb_bw = tcb_dw / 8;
  // byte offset bits inside a word
  localparam int unsigned tcb_bo = $clog2(tcb_bw);

  // response follows the transfer by this many edges
  localparam int unsigned tcb_dly = 1;

  // memory subordinate size
  localparam int unsigned mem_words = 256;
  localparam int unsigned mem_iw    = $clog2(mem_words);
  // first byte address outside the memory
  localparam logic [tcb_aw-1:0] mem_limit = tcb_aw'(mem_words * tcb_bw);

  ////////////////////////////////////////////////////////////
  // bus phases
  ////////////////////////////////////////////////////////////

  // what the manager is doing with this access
  typedef enum logic [1:0] {
    kind_ifu = 2'd0,
    kind_lsu = 2'd1,
    kind_gpr = 2'd2
  } access_kind_e;

  // request phase, manager to subordinate
  typedef struct packed {
    logic              vld;
    logic              wen;
    access_kind_e      kind;
    logic [tcb_aw-1:0] adr;
    logic [tcb_bw-1:0] ben;
    logic [tcb_dw-1:0] wdt;
  } tcb_req_t;

  // response phase, one cycle after the transfer
  typedef struct packed {
    logic [tcb_dw-1:0] rdt;
    logic              err;
  } tcb_rsp_t;

endpackage
